//--- verilog/fwd_gen_pkg.sv
// ----------------------------------------
// Forward data generator shared types
// Packet, descriptor, config and FSM state
// ----------------------------------------

package fwd_gen_pkg;

    // Field widths
    localparam int HOP_W   = 8;
    localparam int DATA_W  = 32;
    localparam int LANE_W  = 2;
    localparam int COUNT_W = 16;

    // Response packet, 42 bits
    typedef struct packed {
        logic [LANE_W-1:0] dest_lane;
        logic [HOP_W-1:0]  hops;
        logic [DATA_W-1:0] data;
    } packet_t;

    // Kernel descriptor, number of packets in the run
    typedef struct packed {
        logic               valid;
        logic [COUNT_W-1:0] count;
    } descriptor_t;

    // Configuration word carrying the hop budget
    typedef struct packed {
        logic             valid;
        logic [HOP_W-1:0] hops;
    } config_t;

    // Packet with its valid strobe, used on every packet port
    typedef struct packed {
        logic    valid;
        packet_t pkt;
    } packet_beat_t;

    // Run control states
    typedef enum logic [2:0] {
        IDLE,
        CFG_REQ,
        CFG_WAIT,
        BUSY,
        PAUSE,
        DRAIN,
        DONE
    } run_state_t;

endpackage

//--- verilog/packet_fifo.sv
// ----------------------------------------
// Synchronous FWFT packet FIFO
// Occupancy counter drives the flags
// ----------------------------------------
`timescale 1ns/1ps

module packet_fifo #(
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  logic                 wr_en,
    input  fwd_gen_pkg::packet_t din,
    input  logic                 rd_en,
    output fwd_gen_pkg::packet_t dout,
    output logic                 empty,
    output logic                 full,
    output logic                 prog_full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LVL_W = $clog2(DEPTH + 1);

    fwd_gen_pkg::packet_t mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [LVL_W-1:0]     level;

    // Storage, head word always visible
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    assign dout = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   level <= level + LVL_W'(1);
                2'b01:   level <= level - LVL_W'(1);
                default: level <= level;
            endcase
        end
    end

    assign empty     = (level == '0);
    assign full      = (level == LVL_W'(DEPTH));
    assign prog_full = (level >= LVL_W'(PROG_THRESH));

    // Writer and reader sit outside, so guard both ends here
    a_no_write_full: assert property (@(posedge ap_clk) disable iff (areset_generator)
        wr_en |-> !full);
    a_no_read_empty: assert property (@(posedge ap_clk) disable iff (areset_generator)
        rd_en |-> !empty);

endmodule

//--- verilog/run_control_fsm.sv
// ----------------------------------------
// Run control FSM
// Descriptor, config fetch, pause and done
// ----------------------------------------
`timescale 1ns/1ps

module run_control_fsm (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  fwd_gen_pkg::descriptor_t      descriptor,
    input  fwd_gen_pkg::config_t          cfg,
    output logic                          cfg_request,
    input  logic                          out_prog_full,
    input  logic                          pipe_idle,
    input  logic                          pop,
    output logic                          pop_enable,
    output logic [fwd_gen_pkg::HOP_W-1:0] hop_budget,
    output logic                          busy,
    output logic                          done
);
    fwd_gen_pkg::run_state_t         state;
    fwd_gen_pkg::run_state_t         next_state;
    logic [fwd_gen_pkg::COUNT_W-1:0] run_count;
    logic [fwd_gen_pkg::COUNT_W-1:0] consumed;
    logic                            accept;
    logic                            count_reached;

    assign accept        = (state == fwd_gen_pkg::IDLE) && descriptor.valid;
    assign count_reached = (consumed == run_count);

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= fwd_gen_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            fwd_gen_pkg::IDLE:     if (descriptor.valid) next_state = fwd_gen_pkg::CFG_REQ;
            fwd_gen_pkg::CFG_REQ:  next_state = fwd_gen_pkg::CFG_WAIT;
            fwd_gen_pkg::CFG_WAIT: if (cfg.valid) next_state = fwd_gen_pkg::BUSY;
            fwd_gen_pkg::BUSY: begin
                // Finishing the count wins over a pause
                if (count_reached) begin
                    next_state = fwd_gen_pkg::DRAIN;
                end else if (out_prog_full) begin
                    next_state = fwd_gen_pkg::PAUSE;
                end
            end
            fwd_gen_pkg::PAUSE:    if (!out_prog_full) next_state = fwd_gen_pkg::BUSY;
            fwd_gen_pkg::DRAIN:    if (pipe_idle) next_state = fwd_gen_pkg::DONE;
            fwd_gen_pkg::DONE:     next_state = fwd_gen_pkg::IDLE;
            default:               next_state = fwd_gen_pkg::IDLE;
        endcase
    end

    // One-cycle config request on leaving CFG_REQ
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cfg_request <= 1'b0;
            consumed    <= '0;
        end else begin
            cfg_request <= (state == fwd_gen_pkg::CFG_REQ);
            if (accept) begin
                consumed <= '0;
            end else if (pop) begin
                consumed <= consumed + fwd_gen_pkg::COUNT_W'(1);
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            run_count <= descriptor.count;
        end
        if ((state == fwd_gen_pkg::CFG_WAIT) && cfg.valid) begin
            hop_budget <= cfg.hops;
        end
    end

    assign pop_enable = (state == fwd_gen_pkg::BUSY) && !count_reached;
    assign busy       = (state != fwd_gen_pkg::IDLE) && (state != fwd_gen_pkg::DONE);
    assign done       = (state == fwd_gen_pkg::DONE);

    // Pop is formed in the top level against the input FIFO
    a_pop_within_count: assert property (@(posedge ap_clk) disable iff (areset_generator)
        pop |-> (consumed < run_count));

endmodule

//--- verilog/hop_forward_stage.sv
// ----------------------------------------
// Hop forwarding stage
// Drops zero-hop packets, subtracts budget
// ----------------------------------------
`timescale 1ns/1ps

module hop_forward_stage (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  fwd_gen_pkg::packet_beat_t     in_beat,
    input  logic [fwd_gen_pkg::HOP_W-1:0] hop_budget,
    output fwd_gen_pkg::packet_beat_t     out_beat
);
    logic                          out_valid_q;
    fwd_gen_pkg::packet_t          out_pkt_q;
    logic [fwd_gen_pkg::HOP_W-1:0] next_hops;
    logic                          forward;

    // Saturating subtract of the budget
    assign next_hops = (in_beat.pkt.hops >= hop_budget) ? (in_beat.pkt.hops - hop_budget) : '0;

    // A packet that arrives with no hops left ends here
    assign forward = in_beat.valid && (in_beat.pkt.hops != '0);

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= forward;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (in_beat.valid) begin
            out_pkt_q <= '{
                dest_lane: in_beat.pkt.dest_lane,
                hops:      next_hops,
                data:      in_beat.pkt.data
            };
        end
    end

    assign out_beat = '{valid: out_valid_q, pkt: out_pkt_q};

endmodule

//--- verilog/lane_credit_gate.sv
// ----------------------------------------
// Lane credit gate
// Releases the output head to its lane
// ----------------------------------------
`timescale 1ns/1ps

module lane_credit_gate #(
    parameter int NUM_LANES    = 4,
    parameter int LANE_CREDITS = 4
) (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  fwd_gen_pkg::packet_t      head,
    input  logic                      head_valid,
    input  logic [NUM_LANES-1:0]      lane_credit,
    output logic                      pop,
    output fwd_gen_pkg::packet_beat_t out_pkt
);
    localparam int CNT_W = $clog2(LANE_CREDITS + 1);

    logic [CNT_W-1:0]     credits [NUM_LANES];
    logic [NUM_LANES-1:0] spend;
    logic                 out_valid_q;
    fwd_gen_pkg::packet_t out_pkt_q;

    // Head waits until its own lane has a credit
    assign pop = head_valid && (credits[head.dest_lane] != '0);

    // ----------------------------------------
    // Per-lane credit counters
    // ----------------------------------------
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        assign spend[k] = pop && (head.dest_lane == fwd_gen_pkg::LANE_W'(k));

        always_ff @(posedge ap_clk) begin
            if (areset_generator) begin
                credits[k] <= CNT_W'(LANE_CREDITS);
            end else begin
                case ({spend[k], lane_credit[k]})
                    2'b10:   credits[k] <= credits[k] - CNT_W'(1);
                    2'b01:   credits[k] <= credits[k] + CNT_W'(1);
                    default: credits[k] <= credits[k];
                endcase
            end
        end

        // Returns come from downstream and must not exceed what was sent
        a_credit_max: assert property (@(posedge ap_clk) disable iff (areset_generator)
            credits[k] <= CNT_W'(LANE_CREDITS));
        // An empty lane stays empty until a credit comes back
        a_credit_min: assert property (@(posedge ap_clk) disable iff (areset_generator)
            (credits[k] == '0) && !lane_credit[k] |=> (credits[k] == '0));
    end

    // Registered launch onto the lane
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop) begin
            out_pkt_q <= head;
        end
    end

    assign out_pkt = '{valid: out_valid_q, pkt: out_pkt_q};

endmodule

//--- verilog/forward_data_generator.sv
// ----------------------------------------
// Forward data generator engine
// Input FIFO, hop stage, output FIFO, lanes
// ----------------------------------------
`timescale 1ns/1ps

module forward_data_generator #(
    parameter int IN_DEPTH     = 16,
    parameter int OUT_DEPTH    = 16,
    parameter int PROG_THRESH  = 8,
    parameter int NUM_LANES    = 4,
    parameter int LANE_CREDITS = 4
) (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  fwd_gen_pkg::descriptor_t  descriptor,
    input  fwd_gen_pkg::config_t      cfg,
    output logic                      cfg_request,
    input  fwd_gen_pkg::packet_beat_t in_pkt,
    output logic                      in_credit,
    output fwd_gen_pkg::packet_beat_t out_pkt,
    input  logic [NUM_LANES-1:0]      lane_credit,
    output logic                      busy,
    output logic                      done
);
    fwd_gen_pkg::packet_t          in_head;
    logic                          in_empty;
    logic                          in_pop;
    logic                          pop_enable;
    logic [fwd_gen_pkg::HOP_W-1:0] hop_budget;
    fwd_gen_pkg::packet_beat_t     stage_beat;
    fwd_gen_pkg::packet_t          out_head;
    logic                          out_empty;
    logic                          out_prog_full;
    logic                          out_pop;
    logic                          pipe_idle;

    // Input side, FIFO empty is only checked here
    assign in_pop    = pop_enable && !in_empty;
    assign pipe_idle = in_empty && out_empty && !stage_beat.valid;

    // Upstream credit follows each pop by one cycle
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= in_pop;
        end
    end

    packet_fifo #(.DEPTH(IN_DEPTH), .PROG_THRESH(IN_DEPTH)) u_in_fifo (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .wr_en(in_pkt.valid), .din(in_pkt.pkt), .rd_en(in_pop), .dout(in_head),
        .empty(in_empty), .full(), .prog_full()
    );

    run_control_fsm u_run_control_fsm (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .descriptor(descriptor), .cfg(cfg), .cfg_request(cfg_request),
        .out_prog_full(out_prog_full), .pipe_idle(pipe_idle), .pop(in_pop),
        .pop_enable(pop_enable), .hop_budget(hop_budget), .busy(busy), .done(done)
    );

    hop_forward_stage u_hop_forward_stage (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .in_beat('{valid: in_pop, pkt: in_head}), .hop_budget(hop_budget),
        .out_beat(stage_beat)
    );

    packet_fifo #(.DEPTH(OUT_DEPTH), .PROG_THRESH(PROG_THRESH)) u_out_fifo (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .wr_en(stage_beat.valid), .din(stage_beat.pkt), .rd_en(out_pop), .dout(out_head),
        .empty(out_empty), .full(), .prog_full(out_prog_full)
    );

    lane_credit_gate #(.NUM_LANES(NUM_LANES), .LANE_CREDITS(LANE_CREDITS)) u_lane_credit_gate (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .head(out_head), .head_valid(!out_empty), .lane_credit(lane_credit),
        .pop(out_pop), .out_pkt(out_pkt)
    );

endmodule

//--- include/fwd_gen_checks.svh
// ----------------------------------------
// Forward data generator check tasks
// ----------------------------------------
`ifndef FWD_GEN_CHECKS_SVH
`define FWD_GEN_CHECKS_SVH

// Common failure exit
task automatic fail_simulation(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
endtask

task automatic check_packet(input string name,
                            input fwd_gen_pkg::packet_t expected,
                            input fwd_gen_pkg::packet_t actual);
    if (actual !== expected) begin
        fail_simulation($sformatf(
            "[ERROR] %s: expected lane %0d hops %0d data %h, actual lane %0d hops %0d data %h",
            name, expected.dest_lane, expected.hops, expected.data,
            actual.dest_lane, actual.hops, actual.data));
    end
endtask

task automatic check_count(input string name,
                           input logic [fwd_gen_pkg::COUNT_W-1:0] expected,
                           input logic [fwd_gen_pkg::COUNT_W-1:0] actual);
    if (actual !== expected) begin
        fail_simulation($sformatf("[ERROR] %s: expected %0d, actual %0d",
                                  name, expected, actual));
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        fail_simulation($sformatf("[ERROR] %s: expected %b, actual %b",
                                  name, expected, actual));
    end
endtask

`endif

//--- bench/tb_forward_data_generator.sv
// ----------------------------------------
// Forward data generator testbench
// Random packets against a hop-rule model
// ----------------------------------------
`timescale 1ns/1ps

module tb_forward_data_generator;

    localparam int IN_DEPTH     = 16;
    localparam int OUT_DEPTH    = 16;
    localparam int PROG_THRESH  = 8;
    localparam int NUM_LANES    = 4;
    localparam int LANE_CREDITS = 4;
    localparam int NUM_RUNS     = 4;
    localparam int RUN_PKTS     = 40;
    localparam int HOLD_CYCLES  = 300;
    localparam int CYCLE_LIMIT  = 200 * NUM_RUNS * RUN_PKTS + 1000;

    logic                      ap_clk;
    logic                      areset_generator;
    fwd_gen_pkg::descriptor_t  descriptor;
    fwd_gen_pkg::config_t      cfg;
    logic                      cfg_request;
    fwd_gen_pkg::packet_beat_t in_pkt;
    logic                      in_credit;
    fwd_gen_pkg::packet_beat_t out_pkt;
    logic [NUM_LANES-1:0]      lane_credit;
    logic                      busy;
    logic                      done;

    integer                        seed = 32'h010f1ce1;
    fwd_gen_pkg::packet_t          model_q [$];
    int                            outstanding [NUM_LANES];
    int                            up_credits;
    int                            send_remaining;
    int                            sent_this_run;
    int                            credit_pulses;
    int                            cfg_pulses;
    int                            done_pulses;
    int                            cycle_count;
    logic [NUM_LANES-1:0]          withhold;
    logic [fwd_gen_pkg::HOP_W-1:0] run_budget;
    logic                          prog_full_seen;

    `include "fwd_gen_checks.svh"

    forward_data_generator #(
        .IN_DEPTH(IN_DEPTH), .OUT_DEPTH(OUT_DEPTH), .PROG_THRESH(PROG_THRESH),
        .NUM_LANES(NUM_LANES), .LANE_CREDITS(LANE_CREDITS)
    ) u_forward_data_generator (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .descriptor(descriptor), .cfg(cfg), .cfg_request(cfg_request),
        .in_pkt(in_pkt), .in_credit(in_credit), .out_pkt(out_pkt),
        .lane_credit(lane_credit), .busy(busy), .done(done)
    );

    always #5 ap_clk = ~ap_clk;

    // ----------------------------------------
    // Per-cycle monitor, feeder and lane returns
    // ----------------------------------------
    always @(negedge ap_clk) begin : cycle_driver
        fwd_gen_pkg::packet_t pkt;
        fwd_gen_pkg::packet_t exp_pkt;
        logic [31:0]          r;
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_simulation("Timeout: the run hung and did not finish within the cycle limit");
        end
        if (!areset_generator) begin
            if (in_credit) begin
                credit_pulses++;
                up_credits++;
                check_flag("upstream credits within depth", 1'b1, up_credits <= IN_DEPTH);
            end
            if (cfg_request) begin
                cfg_pulses++;
                check_flag("busy at cfg_request", 1'b1, busy);
            end
            if (u_forward_data_generator.out_prog_full) begin
                prog_full_seen = 1'b1;
            end
            if (out_pkt.valid) begin
                if (model_q.size() == 0) begin
                    fail_simulation("Output packet appeared when no packet was expected");
                end
                exp_pkt = model_q.pop_front();
                check_packet("out_pkt", exp_pkt, out_pkt.pkt);
                check_flag("busy while packets leave", 1'b1, busy);
                outstanding[out_pkt.pkt.dest_lane]++;
                check_flag("lane outstanding within credits", 1'b1,
                           outstanding[out_pkt.pkt.dest_lane] <= LANE_CREDITS);
            end
            if (done) begin
                done_pulses++;
                check_count("model queue empty at done", '0,
                            fwd_gen_pkg::COUNT_W'(model_q.size()));
            end

            // Upstream feeder, one beat per held credit
            in_pkt = '0;
            r = $random(seed);
            if ((send_remaining > 0) && (up_credits > 0) && (r[1:0] != 2'b00)) begin
                r = $random(seed);
                pkt.dest_lane = fwd_gen_pkg::LANE_W'(r[7:0] % NUM_LANES);
                pkt.hops      = (r[9:8] == 2'b00) ? '0 : r[23:16];
                pkt.data      = $random(seed);
                in_pkt        = '{valid: 1'b1, pkt: pkt};
                up_credits--;
                send_remaining--;
                sent_this_run++;
                // Zero-hop packets are dropped, others lose the budget
                if (pkt.hops != '0) begin
                    exp_pkt      = pkt;
                    exp_pkt.hops = (pkt.hops > run_budget) ? (pkt.hops - run_budget) : '0;
                    model_q.push_back(exp_pkt);
                end
            end

            lane_credit = '0;
            for (int k = 0; k < NUM_LANES; k++) begin
                r = $random(seed);
                if (!withhold[k] && (outstanding[k] > 0) && r[0]) begin
                    lane_credit[k] = 1'b1;
                    outstanding[k]--;
                end
            end
        end
    end

    // ----------------------------------------
    // Run sequence
    // ----------------------------------------
    initial begin
        int delay;
        ap_clk           = 1'b0;
        areset_generator = 1'b1;
        descriptor       = '0;
        cfg              = '0;
        in_pkt           = '0;
        lane_credit      = '0;
        up_credits       = IN_DEPTH;
        send_remaining   = 0;
        sent_this_run    = 0;
        credit_pulses    = 0;
        cfg_pulses       = 0;
        done_pulses      = 0;
        cycle_count      = 0;
        withhold         = '0;
        run_budget       = '0;
        prog_full_seen   = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            outstanding[k] = 0;
        end

        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_generator <= 1'b0;
        check_flag("in_credit low after reset", 1'b0, in_credit);
        check_flag("cfg_request low after reset", 1'b0, cfg_request);
        check_flag("out_pkt valid low after reset", 1'b0, out_pkt.valid);
        check_flag("done low after reset", 1'b0, done);
        check_flag("busy low after reset", 1'b0, busy);

        for (int run = 0; run < NUM_RUNS; run++) begin
            @(negedge ap_clk);
            descriptor = '{valid: 1'b1, count: fwd_gen_pkg::COUNT_W'(RUN_PKTS)};
            @(negedge ap_clk);
            descriptor = '0;

            while (cfg_pulses != run + 1) @(posedge ap_clk);
            case (run)
                0:       run_budget = 8'd0;
                1:       run_budget = 8'd1;
                2:       run_budget = fwd_gen_pkg::HOP_W'($random(seed));
                default: run_budget = 8'd255;
            endcase
            delay = 1 + ($random(seed) & 3);
            repeat (delay) @(negedge ap_clk);
            cfg = '{valid: 1'b1, hops: run_budget};
            @(negedge ap_clk);
            cfg = '0;

            @(posedge ap_clk);
            sent_this_run  = 0;
            prog_full_seen = 1'b0;
            send_remaining = RUN_PKTS;
            // Run 2 stalls lane 1, run 3 stalls every lane
            if (run >= 2) begin
                withhold = (run == 2) ? NUM_LANES'(2) : '1;
                repeat (HOLD_CYCLES) @(posedge ap_clk);
                withhold = '0;
            end

            while (done_pulses != run + 1) @(posedge ap_clk);
            check_count("packets sent", RUN_PKTS, fwd_gen_pkg::COUNT_W'(sent_this_run));
            check_count("in_credit pulses", RUN_PKTS * (run + 1),
                        fwd_gen_pkg::COUNT_W'(credit_pulses));
            check_count("cfg_request pulses", run + 1, fwd_gen_pkg::COUNT_W'(cfg_pulses));
            if (run == 3) begin
                check_flag("output FIFO reached threshold", 1'b1, prog_full_seen);
            end

            repeat (10) begin
                @(negedge ap_clk);
                check_flag("busy low between runs", 1'b0, busy);
            end
            @(posedge ap_clk);
            check_count("done pulses", run + 1, fwd_gen_pkg::COUNT_W'(done_pulses));
            check_count("cfg_request pulses after run", run + 1,
                        fwd_gen_pkg::COUNT_W'(cfg_pulses));
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
verilog/fwd_gen_pkg.sv
verilog/packet_fifo.sv
verilog/run_control_fsm.sv
verilog/hop_forward_stage.sv
verilog/lane_credit_gate.sv
verilog/forward_data_generator.sv
bench/tb_forward_data_generator.sv

//--- Bender.yml
package:
  name: forward_data_generator

sources:
  - include_dirs:
      - include
    files:
      - verilog/fwd_gen_pkg.sv
      - verilog/packet_fifo.sv
      - verilog/run_control_fsm.sv
      - verilog/hop_forward_stage.sv
      - verilog/lane_credit_gate.sv
      - verilog/forward_data_generator.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_forward_data_generator.sv
